/* source/evp_pkg.sv */
package evp_pkg;

	localparam int num_polys = 8;
	localparam int num_coefs = 11;
	localparam int max_degree = num_coefs - 1;
	localparam int coef_depth = num_polys * num_coefs;
	localparam int coef_addr_w = $clog2(coef_depth);
	localparam int degree_slot = 15; // Load index that targets the degree table.

	localparam logic [1:0] op_load = 2'd1;
	localparam logic [1:0] op_eval = 2'd2;

	localparam logic [31:0] status_ok = 32'd0;
	localparam logic [31:0] status_error = 32'd2;
	localparam logic [31:0] status_idle = 32'hffff_ffff;

	typedef struct packed
	{
		logic [1:0] opcode;
		logic [2:0] poly;
		logic [3:0] index;
		logic [6:0] spare;
		logic [15:0] data; // Degree in the low 5 bits for a degree write.
	} load_fmt_t;

	typedef struct packed
	{
		logic [1:0] opcode;
		logic [2:0] poly;
		logic [10:0] spare;
		logic [15:0] x;
	} eval_fmt_t;

	// Opcode sits in bits 31:30 of both layouts.
	typedef union packed
	{
		load_fmt_t load;
		eval_fmt_t eval;
	} instr_t;

	typedef struct packed
	{
		logic en;
		logic is_degree;
		logic [2:0] poly;
		logic [3:0] index;
		logic [15:0] data;
	} table_wr_t;

	typedef struct packed
	{
		logic start;
		logic [2:0] poly;
		logic [15:0] x;
	} eval_req_t;

	typedef struct packed
	{
		logic [15:0] coef;
		logic [4:0] degree;
		logic spare;
	} coef_rd_t;

	typedef struct packed
	{
		logic done;
		logic [31:0] result;
		logic [31:0] status;
	} eval_out_t;

endpackage

/* source/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
(
	input logic clk,
	input logic rst,
	input evp_pkg::instr_t instr,
	input logic instr_valid,
	input logic busy,
	output evp_pkg::table_wr_t wr,
	output evp_pkg::eval_req_t req
);

	logic accept;
	logic index_ok;
	logic is_degree;

	// A start still in flight counts as busy, so no word slips in before busy rises.
	assign accept = instr_valid && !busy && !req.start;

	assign is_degree = instr.load.index == 4'(evp_pkg::degree_slot);
	assign index_ok = (32'(instr.load.index) < evp_pkg::num_coefs) || is_degree;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr <= '0;
			req <= '0;
		end
		else
		begin
			wr.en <= 1'b0; // Both strobes last one cycle.
			req.start <= 1'b0;
			if (accept)
			begin
				case (instr.load.opcode)
					evp_pkg::op_load:
					begin
						if (index_ok)
						begin
							wr.en <= 1'b1;
							wr.is_degree <= is_degree;
							wr.poly <= instr.load.poly;
							wr.index <= instr.load.index;
							wr.data <= instr.load.data;
						end
					end
					evp_pkg::op_eval:
					begin
						req.start <= 1'b1;
						req.poly <= instr.eval.poly;
						req.x <= instr.eval.x;
					end
					default:
					begin
						// Unused opcodes are dropped.
					end
				endcase
			end
		end
	end

endmodule

/* source/coef_store.sv */
`timescale 1ns/1ps

module coef_store
(
	input logic clk,
	input logic rst,
	input evp_pkg::table_wr_t wr,
	input logic [2:0] rd_poly,
	input logic [3:0] rd_index,
	output evp_pkg::coef_rd_t rd
);

	logic [15:0] coef_mem [evp_pkg::coef_depth];
	logic [4:0] degree_mem [evp_pkg::num_polys];
	logic [evp_pkg::coef_addr_w-1:0] wr_addr;
	logic [evp_pkg::coef_addr_w-1:0] rd_addr;

	function automatic logic [evp_pkg::coef_addr_w-1:0] flat_addr
	(
		input logic [2:0] poly,
		input logic [3:0] index
	);
		return evp_pkg::coef_addr_w'(poly) * evp_pkg::coef_addr_w'(evp_pkg::num_coefs)
			+ evp_pkg::coef_addr_w'(index);
	endfunction

	assign wr_addr = flat_addr(wr.poly, wr.index);
	assign rd_addr = flat_addr(rd_poly, rd_index);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < evp_pkg::coef_depth; i++)
				coef_mem[i] <= '0;
			for (int p = 0; p < evp_pkg::num_polys; p++)
				degree_mem[p] <= '0;
			rd <= '0;
		end
		else
		begin
			if (wr.en && wr.is_degree)
				degree_mem[wr.poly] <= wr.data[4:0]; // Degree lives in the low bits.
			else if (wr.en)
				coef_mem[wr_addr] <= wr.data;
			rd.coef <= coef_mem[rd_addr];
			rd.degree <= degree_mem[rd_poly];
			rd.spare <= 1'b0;
		end
	end

endmodule

/* source/poly_eval.sv */
`timescale 1ns/1ps

module poly_eval
(
	input logic clk,
	input logic rst,
	input evp_pkg::eval_req_t req,
	input evp_pkg::coef_rd_t rd,
	output logic [2:0] rd_poly,
	output logic [3:0] rd_index,
	output logic busy,
	output evp_pkg::eval_out_t out
);

	typedef enum logic [2:0]
	{
		st_idle,
		st_setup,
		st_check,
		st_multiply,
		st_accumulate,
		st_error,
		st_finish
	} state_t;

	state_t state;
	state_t next_state;
	logic [2:0] poly_q;
	logic [15:0] x_q;
	logic [4:0] deg_q;
	logic [3:0] term; // Current term index, also the read index.
	logic [3:0] exp_cnt;
	logic [31:0] monomial;
	logic [31:0] sum;
	logic [31:0] sum_next;
	logic deg_bad;

	assign rd_poly = poly_q;
	assign rd_index = term;
	assign busy = state != st_idle;
	assign deg_bad = rd.degree > 5'(evp_pkg::max_degree);
	assign sum_next = sum + monomial * {16'd0, rd.coef};

	always_comb
	begin
		next_state = state;
		case (state)
			st_setup:
				next_state = st_check; // Read of the degree is in flight.
			st_check:
				if (deg_bad)
					next_state = st_error;
				else
					next_state = st_accumulate; // Term 0 needs no multiply.
			st_multiply:
				if (exp_cnt + 4'd1 == term)
					next_state = st_accumulate;
			st_accumulate:
				if ({1'b0, term} == deg_q)
					next_state = st_finish;
				else
					next_state = st_multiply;
			st_error:
				next_state = st_finish;
			default:
				next_state = st_idle;
		endcase
		if (req.start)
			next_state = st_setup; // Start is taken in any state.
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= st_idle;
			poly_q <= '0;
			term <= '0;
			exp_cnt <= '0;
			out <= '{done: 1'b0, result: 32'd0, status: evp_pkg::status_idle};
		end
		else
		begin
			state <= next_state;
			out.done <= 1'b0;
			case (state)
				st_multiply:
					exp_cnt <= exp_cnt + 4'd1;
				st_accumulate:
				begin
					exp_cnt <= '0;
					if (next_state == st_finish)
					begin
						out.done <= 1'b1; // High during the finish cycle.
						out.result <= sum_next;
						out.status <= evp_pkg::status_ok;
					end
					else
						term <= term + 4'd1;
				end
				st_error:
				begin
					out.done <= 1'b1;
					out.result <= 32'd0;
					out.status <= evp_pkg::status_error;
				end
				default:
				begin
				end
			endcase
			if (req.start)
			begin
				poly_q <= req.poly;
				term <= '0;
				exp_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			st_setup:
			begin
				monomial <= 32'd1;
				sum <= 32'd0;
			end
			st_check:
				deg_q <= rd.degree;
			st_multiply:
				monomial <= monomial * {16'd0, x_q}; // Wraps modulo 2^32.
			st_accumulate:
			begin
				sum <= sum_next;
				monomial <= 32'd1;
			end
			default:
			begin
			end
		endcase
		if (req.start)
			x_q <= req.x;
	end

endmodule

/* source/evp_top.sv */
`timescale 1ns/1ps

module evp_top
(
	input logic clk,
	input logic rst,
	input evp_pkg::instr_t instr,
	input logic instr_valid,
	output evp_pkg::eval_out_t out,
	output logic busy
);

	evp_pkg::table_wr_t wr;
	evp_pkg::eval_req_t req;
	evp_pkg::coef_rd_t rd;
	logic [2:0] rd_poly;
	logic [3:0] rd_index;

	instr_decode i_instr_decode
	(
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instr_valid(instr_valid),
		.busy(busy),
		.wr(wr),
		.req(req)
	);

	coef_store i_coef_store
	(
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.rd_poly(rd_poly),
		.rd_index(rd_index),
		.rd(rd)
	);

	poly_eval i_poly_eval
	(
		.clk(clk),
		.rst(rst),
		.req(req),
		.rd(rd),
		.rd_poly(rd_poly),
		.rd_index(rd_index),
		.busy(busy),
		.out(out)
	);

endmodule

/* bench/evp_asserts.sv */
`timescale 1ns/1ps

module evp_asserts
(
	input logic clk,
	input logic rst,
	input evp_pkg::eval_out_t out,
	input logic busy
);

	int fail_count = 0;

	done_after_busy: assert property (@(posedge clk) disable iff (!rst)
		out.done |-> $past(busy))
	else
	begin
		$error("done high without busy in the previous cycle");
		fail_count++;
	end

	// The engine returns to idle right after the done cycle.
	busy_drops: assert property (@(posedge clk) disable iff (!rst)
		out.done |=> !busy)
	else
	begin
		$error("busy still high in the cycle after done");
		fail_count++;
	end

	done_status: assert property (@(posedge clk) disable iff (!rst)
		out.done |-> (out.status == evp_pkg::status_ok || out.status == evp_pkg::status_error))
	else
	begin
		$error("status is neither ok nor error while done is high");
		fail_count++;
	end

endmodule

bind evp_top evp_asserts i_evp_asserts
(
	.clk(clk),
	.rst(rst),
	.out(out),
	.busy(busy)
);

/* bench/evp_tb.sv */
`timescale 1ns/1ps

module evp_tb;

	localparam int wait_limit = 400;

	logic clk;
	logic rst;
	evp_pkg::instr_t instr;
	logic instr_valid;
	evp_pkg::eval_out_t out;
	logic busy;
	int seed;
	int errors;
	logic [15:0] coef_model [8][11];
	logic [4:0] deg_model [8];

	evp_top i_evp_top
	(
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instr_valid(instr_valid),
		.out(out),
		.busy(busy)
	);

	always #50 clk = ~clk;

	// Sum of c_i * x^i modulo 2^32, or 0 when the degree is out of range.
	function automatic logic [31:0] model_eval(input logic [2:0] p, input logic [15:0] x);
		logic [31:0] acc;
		logic [31:0] mono;
		acc = 32'd0;
		if (deg_model[p] > 5'd10)
			return 32'd0;
		for (int k = 0; k <= int'(deg_model[p]); k++)
		begin
			mono = 32'd1;
			for (int e = 0; e < k; e++)
				mono = mono * {16'd0, x};
			acc = acc + mono * {16'd0, coef_model[p][k]};
		end
		return acc;
	endfunction

	task automatic check32(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic issue(input logic [31:0] w);
		instr = w;
		instr_valid = 1'b1;
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	task automatic write_table(input logic [2:0] p, input logic [3:0] idx, input logic [15:0] d);
		issue({evp_pkg::op_load, p, idx, 7'd0, d});
		if (idx == 4'(evp_pkg::degree_slot))
			deg_model[p] = d[4:0];
		else
			coef_model[p][idx] = d;
	endtask

	task automatic wait_for_busy(input logic level);
		int n;
		n = 0;
		while (busy !== level && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (busy !== level)
		begin
			$display("Timeout at %0t ns: busy never went to %b", $time, level);
			errors++;
		end
	endtask

	// Waits for done, compares the result, then waits for the engine to go idle.
	task automatic check_result(input logic [31:0] exp_res, input logic [31:0] exp_stat);
		int n;
		n = 0;
		while (out.done !== 1'b1 && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (out.done !== 1'b1)
		begin
			$display("Timeout at %0t ns: no done pulse after an evaluation", $time);
			errors++;
		end
		else
		begin
			check32("out.result", exp_res, out.result);
			check32("out.status", exp_stat, out.status);
		end
		wait_for_busy(1'b0);
	endtask

	task automatic eval_and_check(input logic [2:0] p, input logic [15:0] x);
		issue({evp_pkg::op_eval, p, 11'd0, x});
		check_result(model_eval(p, x),
			(deg_model[p] > 5'd10) ? evp_pkg::status_error : evp_pkg::status_ok);
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			if (out.done !== 1'b0)
			begin
				$display("Unexpected done pulse at %0t ns after ignored words", $time);
				errors++;
			end
		end
	endtask

	initial
	begin
		logic [31:0] r;
		logic [2:0] p;
		logic [15:0] x;
		evp_pkg::instr_t w;
		int assert_fails;

		seed = 87755;
		errors = 0;
		clk = 1'b0;
		rst = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		for (int i = 0; i < 8; i++)
		begin
			deg_model[i] = '0;
			for (int k = 0; k < 11; k++)
				coef_model[i][k] = '0;
		end
		repeat (8) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		check32("out.done", 32'd0, {31'd0, out.done});
		check32("busy", 32'd0, {31'd0, busy});
		check32("out.result", 32'd0, out.result);
		check32("out.status", evp_pkg::status_idle, out.status);

		for (int i = 0; i < 8; i++)
		begin
			for (int k = 0; k < 11; k++)
			begin
				r = $random(seed);
				write_table(3'(i), 4'(k), r[15:0]);
			end
			r = $random(seed);
			write_table(3'(i), 4'(evp_pkg::degree_slot), 16'(r % 32'd11));
		end
		repeat (30)
		begin
			r = $random(seed);
			eval_and_check(r[18:16], r[15:0]);
		end

		// Degree above 10 gives the error status.
		r = $random(seed);
		p = r[2:0];
		write_table(p, 4'(evp_pkg::degree_slot), 16'(32'd11 + r[15:8] % 32'd21));
		eval_and_check(p, r[31:16]);
		write_table(p, 4'(evp_pkg::degree_slot), 16'(r[23:16] % 8'd11));
		eval_and_check(p, r[31:16]);

		// Words sent during a long run are lost.
		write_table(3'd0, 4'(evp_pkg::degree_slot), 16'd10);
		r = $random(seed);
		x = r[15:0];
		issue({evp_pkg::op_eval, 3'd0, 11'd0, x});
		wait_for_busy(1'b1);
		issue({evp_pkg::op_eval, 3'd5, 11'd0, r[31:16]});
		issue({evp_pkg::op_load, 3'd5, 4'd0, 7'd0, ~coef_model[5][0]});
		if (busy !== 1'b1)
		begin
			$display("Run ended before the dropped words were sent at %0t ns", $time);
			errors++;
		end
		check_result(model_eval(3'd0, x), evp_pkg::status_ok);
		expect_quiet(20);
		eval_and_check(3'd5, x);

		// Unused opcodes and load indices 11 to 14.
		repeat (4)
		begin
			w = $random(seed);
			w.load.opcode = 2'd0;
			issue(w);
			w = $random(seed);
			w.load.opcode = 2'd3;
			issue(w);
		end
		for (int k = 11; k <= 14; k++)
		begin
			r = $random(seed);
			issue({evp_pkg::op_load, r[2:0], 4'(k), 7'd0, r[31:16]});
		end
		expect_quiet(20);
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			eval_and_check(3'(i), r[15:0]);
		end

		assert_fails = i_evp_top.i_evp_asserts.fail_count;
		$display("Errors: %0d, assertion failures: %0d", errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* project.f */
source/evp_pkg.sv
source/instr_decode.sv
source/coef_store.sv
source/poly_eval.sv
source/evp_top.sv
bench/evp_asserts.sv
bench/evp_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module evp_tb -Mdir obj_dir
	./obj_dir/Vevp_tb +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
